/* design/core_pkg.sv */
`default_nettype none

`include "core_macros.svh"

package core_pkg;

    // major opcodes handled by the pipeline
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // fetch to decode
    typedef struct packed {
        logic                  valid;
        logic [`CORE_XLEN-1:0] pc;
        logic [`CORE_XLEN-1:0] instr;
    } fetch_pkt_t;

    // decode to execute, operands already resolved
    typedef struct packed {
        logic                    valid;
        alu_op_t                 alu_op;
        logic [`CORE_XLEN-1:0]   op_a;
        logic [`CORE_XLEN-1:0]   op_b;
        logic [`CORE_REG_AW-1:0] rd;
        logic                    we;
    } dec_pkt_t;

    // register write, used for forwarding, writeback and retire
    typedef struct packed {
        logic                    we;
        logic [`CORE_REG_AW-1:0] rd;
        logic [`CORE_XLEN-1:0]   data;
    } wb_pkt_t;

endpackage

`default_nettype wire

/* design/core_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "core_macros.svh"

module core_top (
    input  wire                        clk_i,
    input  wire                        rst_n_i,
    output logic                       rom_ce_o,
    output logic [`CORE_XLEN-1:0]      rom_addr_o,
    input  wire  [`CORE_XLEN-1:0]      rom_data_i,
    output core_pkg::wb_pkt_t          retire_o
);

    import core_pkg::*;

    fetch_pkt_t              fetch_pkt;
    dec_pkt_t                dec_pkt;
    wb_pkt_t                 ex_fwd;
    wb_pkt_t                 wb_pkt;
    logic [`CORE_REG_AW-1:0] rs1_addr;
    logic [`CORE_REG_AW-1:0] rs2_addr;
    logic [`CORE_XLEN-1:0]   rs1_data;
    logic [`CORE_XLEN-1:0]   rs2_data;

    fetch_unit u_fetch (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rom_ce_o   (rom_ce_o),
        .rom_addr_o (rom_addr_o),
        .rom_data_i (rom_data_i),
        .fetch_o    (fetch_pkt)
    );

    decode_unit u_decode (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .fetch_i    (fetch_pkt),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .ex_fwd_i   (ex_fwd),
        .wb_fwd_i   (wb_pkt),
        .dec_o      (dec_pkt)
    );

    regfile u_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_i       (wb_pkt)
    );

    exec_unit u_exec (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .dec_i    (dec_pkt),
        .ex_fwd_o (ex_fwd),
        .wb_o     (wb_pkt)
    );

    // every register write is reported as a retire
    assign retire_o = wb_pkt;

endmodule

`default_nettype wire

/* design/decode_unit.sv */
`default_nettype none
`timescale 1ns/1ps

`include "core_macros.svh"

module decode_unit (
    input  wire                          clk_i,
    input  wire                          rst_n_i,
    input  wire core_pkg::fetch_pkt_t    fetch_i,
    output logic [`CORE_REG_AW-1:0]      rs1_addr_o,
    output logic [`CORE_REG_AW-1:0]      rs2_addr_o,
    input  wire  [`CORE_XLEN-1:0]        rs1_data_i,
    input  wire  [`CORE_XLEN-1:0]        rs2_data_i,
    input  wire core_pkg::wb_pkt_t       ex_fwd_i,
    input  wire core_pkg::wb_pkt_t       wb_fwd_i,
    output core_pkg::dec_pkt_t           dec_o
);

    import core_pkg::*;

    opcode_t                 opcode;
    logic [2:0]              funct3;
    logic [`CORE_XLEN-1:0]   imm_i;
    logic [`CORE_XLEN-1:0]   imm_u;
    logic [`CORE_XLEN-1:0]   rs1_val;
    logic [`CORE_XLEN-1:0]   rs2_val;
    logic                    supported;
    dec_pkt_t                dec_next;

    // youngest producer wins and x0 never forwards
    function automatic logic [`CORE_XLEN-1:0] resolve_operand(
        input logic [`CORE_REG_AW-1:0] addr,
        input logic [`CORE_XLEN-1:0]   rf_data,
        input wb_pkt_t                 ex_fwd,
        input wb_pkt_t                 wb_fwd
    );
        if (addr == '0) begin
            return '0;
        end else if (ex_fwd.we && ex_fwd.rd == addr) begin
            return ex_fwd.data;
        end else if (wb_fwd.we && wb_fwd.rd == addr) begin
            return wb_fwd.data;
        end
        return rf_data;
    endfunction

    // funct7 bit 30 picks sub and sra; sub only exists for register form
    function automatic alu_op_t alu_select(
        input logic [2:0] f3,
        input logic       alt,
        input logic       is_reg
    );
        case (f3)
            3'b000:  return (is_reg && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign rs1_addr_o = fetch_i.instr[19:15];
    assign rs2_addr_o = fetch_i.instr[24:20];

    assign opcode = opcode_t'(fetch_i.instr[6:0]);
    assign funct3 = fetch_i.instr[14:12];
    assign imm_i  = {{(`CORE_XLEN-12){fetch_i.instr[31]}}, fetch_i.instr[31:20]};
    assign imm_u  = {fetch_i.instr[31:12], 12'b0};

    assign rs1_val = resolve_operand(rs1_addr_o, rs1_data_i, ex_fwd_i, wb_fwd_i);
    assign rs2_val = resolve_operand(rs2_addr_o, rs2_data_i, ex_fwd_i, wb_fwd_i);

    always_comb begin
        dec_next.valid  = fetch_i.valid;
        dec_next.alu_op = ALU_ADD;
        dec_next.op_a   = rs1_val;
        dec_next.op_b   = imm_i;
        dec_next.rd     = fetch_i.instr[11:7];
        supported       = 1'b1;

        case (opcode)
            OPC_OP_IMM: begin
                dec_next.alu_op = alu_select(funct3, fetch_i.instr[30], 1'b0);
            end
            OPC_OP: begin
                dec_next.alu_op = alu_select(funct3, fetch_i.instr[30], 1'b1);
                dec_next.op_b   = rs2_val;
            end
            OPC_LUI: begin
                dec_next.op_a = '0;
                dec_next.op_b = imm_u;
            end
            OPC_AUIPC: begin
                dec_next.op_a = fetch_i.pc;
                dec_next.op_b = imm_u;
            end
            default: begin
                supported = 1'b0;
            end
        endcase

        // unknown opcodes and rd of x0 pass through without a write
        dec_next.we = supported && (dec_next.rd != '0);
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_o.valid <= 1'b0;
            dec_o.we    <= 1'b0;
        end else begin
            dec_o <= dec_next;
        end
    end

endmodule

`default_nettype wire

/* design/exec_unit.sv */
`default_nettype none
`timescale 1ns/1ps

`include "core_macros.svh"

module exec_unit (
    input  wire                        clk_i,
    input  wire                        rst_n_i,
    input  wire core_pkg::dec_pkt_t    dec_i,
    output core_pkg::wb_pkt_t          ex_fwd_o,
    output core_pkg::wb_pkt_t          wb_o
);

    import core_pkg::*;

    logic [4:0]            shamt;
    logic                  lt_signed;
    logic                  lt_unsigned;
    logic [`CORE_XLEN-1:0] alu_result;

    // shifts only look at the low five bits of operand b
    assign shamt       = dec_i.op_b[4:0];
    assign lt_signed   = $signed(dec_i.op_a) < $signed(dec_i.op_b);
    assign lt_unsigned = dec_i.op_a < dec_i.op_b;

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:  alu_result = dec_i.op_a + dec_i.op_b;
            ALU_SUB:  alu_result = dec_i.op_a - dec_i.op_b;
            ALU_SLL:  alu_result = dec_i.op_a << shamt;
            ALU_SLT:  alu_result = {{(`CORE_XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: alu_result = {{(`CORE_XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  alu_result = dec_i.op_a ^ dec_i.op_b;
            ALU_SRL:  alu_result = dec_i.op_a >> shamt;
            ALU_SRA:  alu_result = $unsigned($signed(dec_i.op_a) >>> shamt);
            ALU_OR:   alu_result = dec_i.op_a | dec_i.op_b;
            ALU_AND:  alu_result = dec_i.op_a & dec_i.op_b;
            default:  alu_result = '0;
        endcase
    end

    // result still in execute, back to decode this cycle
    always_comb begin
        ex_fwd_o.we   = dec_i.valid & dec_i.we;
        ex_fwd_o.rd   = dec_i.rd;
        ex_fwd_o.data = alu_result;
    end

    // writeback register, also the retire report
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_o.we <= 1'b0;
        end else begin
            wb_o <= ex_fwd_o;
        end
    end

endmodule

`default_nettype wire

/* design/fetch_unit.sv */
`default_nettype none
`timescale 1ns/1ps

`include "core_macros.svh"

module fetch_unit (
    input  wire                        clk_i,
    input  wire                        rst_n_i,
    output logic                       rom_ce_o,
    output logic [`CORE_XLEN-1:0]      rom_addr_o,
    input  wire  [`CORE_XLEN-1:0]      rom_data_i,
    output core_pkg::fetch_pkt_t       fetch_o
);

    logic [`CORE_XLEN-1:0] pc_q;

    assign rom_addr_o = pc_q;

    // rom enable rises one cycle after reset is released
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rom_ce_o <= 1'b0;
            pc_q     <= `CORE_RESET_PC;
        end else begin
            rom_ce_o <= 1'b1;
            // hold the reset pc until the first word has been fetched
            if (rom_ce_o) begin
                pc_q <= pc_q + `CORE_PC_STEP;
            end
        end
    end

    // rom answers in the same cycle, so capture pc and word together
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fetch_o.valid <= 1'b0;
        end else begin
            fetch_o.valid <= rom_ce_o;
            fetch_o.pc    <= pc_q;
            fetch_o.instr <= rom_data_i;
        end
    end

endmodule

`default_nettype wire

/* design/regfile.sv */
`default_nettype none
`timescale 1ns/1ps

`include "core_macros.svh"

module regfile (
    input  wire                        clk_i,
    input  wire                        rst_n_i,
    input  wire  [`CORE_REG_AW-1:0]    rs1_addr_i,
    input  wire  [`CORE_REG_AW-1:0]    rs2_addr_i,
    output logic [`CORE_XLEN-1:0]      rs1_data_o,
    output logic [`CORE_XLEN-1:0]      rs2_data_o,
    input  wire core_pkg::wb_pkt_t     wr_i
);

    logic [`CORE_XLEN-1:0] regs_q [`CORE_REG_COUNT];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_i.we && wr_i.rd != '0) begin
            regs_q[wr_i.rd] <= wr_i.data;
        end
    end

    // combinational reads, x0 hardwired
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
design/core_pkg.sv
design/fetch_unit.sv
design/decode_unit.sv
design/regfile.sv
design/exec_unit.sv
design/core_top.sv
test/tb_core_top.sv

/* include/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// data path and address width
`define CORE_XLEN 32

// integer register file geometry
`define CORE_REG_COUNT 32
`define CORE_REG_AW 5

// first fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

// sequential fetch step, one word per cycle
`define CORE_PC_STEP 32'd4

`endif

/* run.sh */
#!/usr/bin/env bash
# build and run the core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -f flist.f --top-module tb_core_top \
    -Mdir "$build_dir" -o tb_core_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/tb_core_top" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$log_file"; then
    exit 0
fi
echo "pass message not found in $log_file"
exit 1

/* test/core_tests.dat */
# I <instruction word hex> <rd expected to retire, 0 for none> <expected value hex>
I 00500093 1 00000005
I ffd00113 2 fffffffd
I ffe12193 3 00000001
I fff13213 4 00000001
I ffd12293 5 00000000
I 40115313 6 fffffffe
I 01c15393 7 0000000f
I 00409413 8 00000050
I fff0c493 9 fffffffa
I 0700e513 10 00000075
I 0f017593 11 000000f0
I 40100633 12 fffffffb
I 001606b3 13 00000000
I 40165733 14 ffffffff
I 001657b3 15 07ffffff
I 00109833 16 000000a0
I 001628b3 17 00000001
I 00163933 18 00000000
I 0020c9b3 19 fffffff8
I 00a0ea33 20 00000075
I 00b17ab3 21 000000f0
I 12345b37 22 12345000
I 00001b97 23 00001058
I 00102423 0 00000000
I 00708013 0 00000000
I 00800c33 24 00000050

/* test/tb_core_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "core_macros.svh"

module tb_core_top;

    import core_pkg::*;

    // addi x0, x0, 0
    localparam logic [`CORE_XLEN-1:0] NOP_WORD = 32'h0000_0013;

    logic                  clk;
    logic                  rst_n;
    logic                  rom_ce;
    logic [`CORE_XLEN-1:0] rom_addr;
    logic [`CORE_XLEN-1:0] rom_data;
    wb_pkt_t               retire;

    logic [`CORE_XLEN-1:0] prog_mem [256];
    logic [`CORE_XLEN-1:0] prog_len;
    logic [`CORE_XLEN-1:0] exp_pc;
    wb_pkt_t               exp_q [$];
    int                    reset_edges;
    int                    cycles;
    int                    cycle_limit;
    int                    retire_errors;
    int                    fetch_errors;
    int                    order_errors;

    core_top dut (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .rom_ce_o   (rom_ce),
        .rom_addr_o (rom_addr),
        .rom_data_i (rom_data),
        .retire_o   (retire)
    );

    // combinational rom, nops past the end of the program
    assign rom_data = ((rom_addr >> 2) < prog_len) ? prog_mem[rom_addr[9:2]] : NOP_WORD;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_fetch(
        input logic                  got_ce,
        input logic [`CORE_XLEN-1:0] got_addr,
        input logic                  exp_ce,
        input logic [`CORE_XLEN-1:0] exp_addr
    );
        if (got_ce !== exp_ce || (exp_ce && got_addr !== exp_addr)) begin
            $display("Fail at %0t ns: fetch ce %b addr %h, expected ce %b addr %h",
                     $time, got_ce, got_addr, exp_ce, exp_addr);
            fetch_errors++;
        end
    endtask

    task automatic check_retire(input wb_pkt_t got, input wb_pkt_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: retire x%0d = %h, expected x%0d = %h",
                     $time, got.rd, got.data, exp.rd, exp.data);
            retire_errors++;
        end
    endtask

    // registered outputs sampled at the rising edge, before they change
    always @(posedge clk) begin
        if (!rst_n) begin
            if (reset_edges > 0) begin
                check_fetch(rom_ce, rom_addr, 1'b0, exp_pc);
            end
            reset_edges++;
        end else begin
            cycles++;
            // enable rises at the first edge after release
            check_fetch(rom_ce, rom_addr, cycles > 1, exp_pc);
            if (cycles > 1) begin
                exp_pc += 4;
            end
            if (retire.we) begin
                if (exp_q.size() == 0) begin
                    $display("retire of x%0d = %h at %0t ns is beyond the expected list",
                             retire.rd, retire.data, $time);
                    order_errors++;
                end else begin
                    check_retire(retire, exp_q.pop_front());
                end
            end
        end
    end

    initial begin
        int                    fd;
        int                    rc;
        int                    rd_num;
        logic [7:0]            tag;
        logic [`CORE_XLEN-1:0] word;
        logic [`CORE_XLEN-1:0] value;
        logic [8*96-1:0]       line;
        wb_pkt_t               entry;

        rst_n    = 1'b0;
        prog_len = '0;
        exp_pc   = `CORE_RESET_PC;

        fd = $fopen("test/core_tests.dat", "r");
        if (fd == 0) begin
            $display("could not open test/core_tests.dat");
            order_errors++;
        end else begin
            while ($fscanf(fd, " %c", tag) == 1) begin
                if (tag == "I") begin
                    rc = $fscanf(fd, "%h %d %h", word, rd_num, value);
                    if (rc != 3) begin
                        $display("malformed line after word %0d in the test file", prog_len);
                        order_errors++;
                    end
                    prog_mem[prog_len[7:0]] = word;
                    prog_len++;
                    // x0 never retires, so rd 0 marks no retire
                    if (rd_num != 0) begin
                        entry.we   = 1'b1;
                        entry.rd   = rd_num[4:0];
                        entry.data = value;
                        exp_q.push_back(entry);
                    end
                end else begin
                    rc = $fgets(line, fd);
                end
            end
            $fclose(fd);
        end
        cycle_limit = int'(prog_len) + 20;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // run until all entries retired and the last word has left the pipe
        while ((exp_q.size() != 0 || rom_addr < (prog_len + 3) * 4) && cycles < cycle_limit) begin
            @(negedge clk);
        end

        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles", cycles);
            order_errors++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected retires were never seen", exp_q.size());
            order_errors += exp_q.size();
        end

        $display("errors: retire %0d, fetch %0d, sequence %0d",
                 retire_errors, fetch_errors, order_errors);
        if (retire_errors + fetch_errors + order_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
